/* include/uart_config.svh */
/*
 * Serial port configuration
 * Default clocks per bit and receive queue depth
 */

`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Clocks per serial bit, same for both directions
`define UART_BAUD_DIVIDE 8

// Receive queue entries, must be a power of two
`define UART_FIFO_DEPTH 8

`endif

/* logic/uart_types_pkg.sv */
/*
 * Serial engine types
 * Character, counter widths and engine state encodings
 */

package uart_types_pkg;

	// One 8N1 data character
	typedef logic [7:0] char_t;

	// Baud countdown, wide enough for slow rates on fast clocks
	typedef logic [11:0] sample_count_t;

	// Bit position within a frame
	typedef logic [3:0] bit_count_t;

	typedef enum logic
	{
		RX_WAIT_START,
		RX_READ_CHARACTER
	} rx_state_t;

	typedef enum logic [1:0]
	{
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

endpackage

/* logic/io_bus_pkg.sv */
/*
 * I/O bus definitions
 * Bus widths, register map and status bit layout
 */

package io_bus_pkg;

	typedef logic [3:0] io_addr_t;
	typedef logic [31:0] io_data_t;

	// Register byte offsets
	localparam io_addr_t REG_STATUS = 4'd0;
	localparam io_addr_t REG_RX_DATA = 4'd4;
	localparam io_addr_t REG_TX_DATA = 4'd8;

	// Status register bits
	localparam int STATUS_RX_READY = 0;
	localparam int STATUS_TX_READY = 1;
	localparam int STATUS_OVERRUN = 2;

endpackage

/* logic/synchronizer.sv */
/*
 * Two-stage synchronizer for an asynchronous input line
 */

`timescale 1ns/1ps

module synchronizer
	#(parameter logic RESET_STATE = 1'b1)
	(input clk,
	input reset,
	input logic data_i,
	output logic data_o);

	// First stage may go metastable, second one settles it
	logic sync_stage1;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			sync_stage1 <= RESET_STATE;
			data_o <= RESET_STATE;
		end
		else
		begin
			sync_stage1 <= data_i;
			data_o <= sync_stage1;
		end
	end
endmodule

/* logic/uart_receive.sv */
/*
 * Serial receiver
 * Finds the start edge, samples each bit at its middle and
 * assembles an 8N1 character, LSB first
 */

`timescale 1ns/1ps

`include "uart_config.svh"

module uart_receive
	#(parameter int BAUD_DIVIDE = `UART_BAUD_DIVIDE)
	(input clk,
	input reset,
	input logic uart_rx,
	output uart_types_pkg::char_t rx_char,
	output logic rx_char_valid);

	import uart_types_pkg::*;

	rx_state_t state_ff;
	rx_state_t state_nxt;
	sample_count_t sample_count_ff;
	sample_count_t sample_count_nxt;
	bit_count_t bit_count_ff;
	bit_count_t bit_count_nxt;
	char_t shift_register;
	logic do_shift;
	logic rx_sync;

	// Assembled character is valid while the stop bit is sampled
	assign rx_char = shift_register;

	// Idle line is high, so reset to 1 to avoid a false start
	synchronizer #(.RESET_STATE(1'b1)) rx_synchronizer(
		.clk(clk),
		.reset(reset),
		.data_i(uart_rx),
		.data_o(rx_sync));

	always_comb
	begin
		state_nxt = state_ff;
		sample_count_nxt = sample_count_ff;
		bit_count_nxt = bit_count_ff;
		rx_char_valid = 1'b0;
		do_shift = 1'b0;

		unique case (state_ff)
			RX_WAIT_START:
			begin
				if (!rx_sync)
				begin
					state_nxt = RX_READ_CHARACTER;

					// Start edge seen; skip start bit plus half a bit
					// to land in the middle of data bit 0
					sample_count_nxt = sample_count_t'(BAUD_DIVIDE * 3 / 2 - 1);
				end
			end

			RX_READ_CHARACTER:
			begin
				if (sample_count_ff == '0)
				begin
					sample_count_nxt = sample_count_t'(BAUD_DIVIDE - 1);
					if (bit_count_ff == bit_count_t'(8))
					begin
						// Stop bit sample point, character complete
						state_nxt = RX_WAIT_START;
						rx_char_valid = 1'b1;
						bit_count_nxt = '0;
					end
					else
					begin
						do_shift = 1'b1;
						bit_count_nxt = bit_count_ff + bit_count_t'(1);
					end
				end
				else
					sample_count_nxt = sample_count_ff - sample_count_t'(1);
			end
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_ff <= RX_WAIT_START;
			sample_count_ff <= '0;
			bit_count_ff <= '0;
		end
		else
		begin
			state_ff <= state_nxt;
			sample_count_ff <= sample_count_nxt;
			bit_count_ff <= bit_count_nxt;
		end
	end

	// Character bits shift in from the top, LSB arrives first
	always_ff @(posedge clk)
	begin
		if (do_shift)
			shift_register <= {rx_sync, shift_register[7:1]};
	end
endmodule

/* logic/uart_transmit.sv */
/*
 * Serial transmitter
 * Sends one character as start bit, 8 data bits LSB first
 * and a stop bit, each BAUD_DIVIDE clocks long
 */

`timescale 1ns/1ps

`include "uart_config.svh"

module uart_transmit
	#(parameter int BAUD_DIVIDE = `UART_BAUD_DIVIDE)
	(input clk,
	input reset,
	input logic tx_start,
	input uart_types_pkg::char_t tx_char,
	output logic tx_ready,
	output logic uart_tx);

	import uart_types_pkg::*;

	tx_state_t state_ff;
	tx_state_t state_nxt;
	sample_count_t baud_count_ff;
	sample_count_t baud_count_nxt;
	bit_count_t bit_count_ff;
	bit_count_t bit_count_nxt;
	char_t shift_ff;
	char_t shift_nxt;
	logic uart_tx_nxt;

	// New character only accepted between frames
	assign tx_ready = state_ff == TX_IDLE;

	always_comb
	begin
		state_nxt = state_ff;
		baud_count_nxt = baud_count_ff;
		bit_count_nxt = bit_count_ff;
		shift_nxt = shift_ff;
		uart_tx_nxt = uart_tx;

		unique case (state_ff)
			TX_IDLE:
			begin
				if (tx_start)
				begin
					// Line drops on the next edge
					state_nxt = TX_START;
					uart_tx_nxt = 1'b0;
					shift_nxt = tx_char;
					baud_count_nxt = sample_count_t'(BAUD_DIVIDE - 1);
				end
			end

			TX_START,
			TX_DATA:
			begin
				if (baud_count_ff == '0)
				begin
					baud_count_nxt = sample_count_t'(BAUD_DIVIDE - 1);
					if (state_ff == TX_DATA && bit_count_ff == bit_count_t'(7))
					begin
						// Last data bit done, send stop bit
						state_nxt = TX_STOP;
						uart_tx_nxt = 1'b1;
					end
					else
					begin
						// Next data bit, LSB first
						uart_tx_nxt = shift_ff[0];
						shift_nxt = {1'b1, shift_ff[7:1]};
						if (state_ff == TX_START)
							bit_count_nxt = '0;
						else
							bit_count_nxt = bit_count_ff + bit_count_t'(1);
						state_nxt = TX_DATA;
					end
				end
				else
					baud_count_nxt = baud_count_ff - sample_count_t'(1);
			end

			TX_STOP:
			begin
				// Line already high, just wait out the stop bit
				if (baud_count_ff == '0)
					state_nxt = TX_IDLE;
				else
					baud_count_nxt = baud_count_ff - sample_count_t'(1);
			end
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_ff <= TX_IDLE;
			baud_count_ff <= '0;
			bit_count_ff <= '0;
			uart_tx <= 1'b1;
		end
		else
		begin
			state_ff <= state_nxt;
			baud_count_ff <= baud_count_nxt;
			bit_count_ff <= bit_count_nxt;
			uart_tx <= uart_tx_nxt;
		end
	end

	always_ff @(posedge clk)
		shift_ff <= shift_nxt;
endmodule

/* logic/uart_rx_fifo.sv */
/*
 * Receive character queue
 * Circular buffer with a sticky overrun flag for dropped characters
 */

`timescale 1ns/1ps

`include "uart_config.svh"

module uart_rx_fifo
	#(parameter int DEPTH = `UART_FIFO_DEPTH)
	(input clk,
	input reset,
	input logic push,
	input uart_types_pkg::char_t push_char,
	input logic pop,
	output uart_types_pkg::char_t pop_char,
	output logic empty,
	output logic overrun,
	input logic overrun_clear);

	import uart_types_pkg::*;

	localparam int ADDR_WIDTH = $clog2(DEPTH);
	localparam int COUNT_WIDTH = $clog2(DEPTH + 1);
	localparam logic [COUNT_WIDTH-1:0] FULL_COUNT = COUNT_WIDTH'(DEPTH);

	char_t storage[DEPTH];
	logic [ADDR_WIDTH-1:0] read_ptr;
	logic [ADDR_WIDTH-1:0] write_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic full;
	logic push_accept;

	assign empty = count == '0;
	assign full = count == FULL_COUNT;

	// A pop in the same cycle frees the slot the push needs
	assign push_accept = push && (!full || pop);

	// Head of queue, read combinationally
	assign pop_char = storage[read_ptr];

	always_ff @(posedge clk)
	begin
		if (push_accept)
			storage[write_ptr] <= push_char;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
			overrun <= 1'b0;
		end
		else
		begin
			// Pointers wrap on their own since DEPTH is a power of two
			if (push_accept)
				write_ptr <= write_ptr + 1'b1;
			if (pop)
				read_ptr <= read_ptr + 1'b1;

			if (push_accept && !pop)
				count <= count + 1'b1;
			else if (pop && !push_accept)
				count <= count - 1'b1;

			// Dropped character sets the flag, even against a clear
			if (push && !push_accept)
				overrun <= 1'b1;
			else if (overrun_clear)
				overrun <= 1'b0;
		end
	end
endmodule

/* logic/uart_io_decode.sv */
/*
 * I/O bus register decoder
 * Turns bus strobes into pop, clear and start pulses and
 * returns register contents one clock after a read
 */

`timescale 1ns/1ps

module uart_io_decode
	(input clk,
	input reset,
	input io_bus_pkg::io_addr_t io_address,
	input logic io_read_en,
	input logic io_write_en,
	input io_bus_pkg::io_data_t io_write_data,
	output io_bus_pkg::io_data_t io_read_data,
	input logic rx_empty,
	input uart_types_pkg::char_t rx_char,
	input logic rx_overrun,
	output logic rx_pop,
	output logic overrun_clear,
	input logic tx_ready,
	output logic tx_start,
	output uart_types_pkg::char_t tx_char);

	import io_bus_pkg::*;

	io_data_t read_value;

	// Status read reports overrun and clears it on the same edge
	assign overrun_clear = io_read_en && io_address == REG_STATUS;

	// Only pop a character that is actually there
	assign rx_pop = io_read_en && io_address == REG_RX_DATA && !rx_empty;

	// Writes while a frame is in flight are dropped
	assign tx_start = io_write_en && io_address == REG_TX_DATA && tx_ready;
	assign tx_char = io_write_data[7:0];

	// Read mux, unknown offsets read as zero
	always_comb
	begin
		read_value = '0;
		case (io_address)
			REG_STATUS:
			begin
				read_value[STATUS_RX_READY] = !rx_empty;
				read_value[STATUS_TX_READY] = tx_ready;
				read_value[STATUS_OVERRUN] = rx_overrun;
			end

			REG_RX_DATA:
			begin
				if (!rx_empty)
					read_value[7:0] = rx_char;
			end

			default:
				read_value = '0;
		endcase
	end

	// Result held until the next read
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			io_read_data <= '0;
		else if (io_read_en)
			io_read_data <= read_value;
	end
endmodule

/* logic/uart_top.sv */
/*
 * Memory-mapped serial port
 * Register decoder, receive queue and the two serial engines
 */

`timescale 1ns/1ps

`include "uart_config.svh"

module uart_top
	#(parameter int BAUD_DIVIDE = `UART_BAUD_DIVIDE,
	parameter int FIFO_DEPTH = `UART_FIFO_DEPTH)
	(input clk,
	input reset,
	input io_bus_pkg::io_addr_t io_address,
	input logic io_read_en,
	input logic io_write_en,
	input io_bus_pkg::io_data_t io_write_data,
	output io_bus_pkg::io_data_t io_read_data,
	input logic uart_rx,
	output logic uart_tx);

	import uart_types_pkg::*;

	// Receive side
	char_t rx_char;
	logic rx_char_valid;
	char_t fifo_char;
	logic fifo_empty;
	logic fifo_overrun;
	logic rx_pop;
	logic overrun_clear;

	// Transmit side
	logic tx_ready;
	logic tx_start;
	char_t tx_char;

	uart_io_decode io_decode(
		.clk(clk),
		.reset(reset),
		.io_address(io_address),
		.io_read_en(io_read_en),
		.io_write_en(io_write_en),
		.io_write_data(io_write_data),
		.io_read_data(io_read_data),
		.rx_empty(fifo_empty),
		.rx_char(fifo_char),
		.rx_overrun(fifo_overrun),
		.rx_pop(rx_pop),
		.overrun_clear(overrun_clear),
		.tx_ready(tx_ready),
		.tx_start(tx_start),
		.tx_char(tx_char));

	uart_rx_fifo #(.DEPTH(FIFO_DEPTH)) rx_fifo(
		.clk(clk),
		.reset(reset),
		.push(rx_char_valid),
		.push_char(rx_char),
		.pop(rx_pop),
		.pop_char(fifo_char),
		.empty(fifo_empty),
		.overrun(fifo_overrun),
		.overrun_clear(overrun_clear));

	uart_receive #(.BAUD_DIVIDE(BAUD_DIVIDE)) receive(
		.clk(clk),
		.reset(reset),
		.uart_rx(uart_rx),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid));

	uart_transmit #(.BAUD_DIVIDE(BAUD_DIVIDE)) transmit(
		.clk(clk),
		.reset(reset),
		.tx_start(tx_start),
		.tx_char(tx_char),
		.tx_ready(tx_ready),
		.uart_tx(uart_tx));
endmodule

/* dv/uart_chk.sv */
/*
 * Serial port protocol checker
 * Concurrent assertions bound into the top level
 */

`timescale 1ns/1ps

module uart_chk
	(input clk,
	input reset,
	input logic uart_tx,
	input logic tx_ready,
	input logic tx_start,
	input logic rx_char_valid,
	input logic rx_pop,
	input logic fifo_empty,
	input uart_types_pkg::char_t fifo_char,
	input io_bus_pkg::io_data_t io_read_data);

	// Count of failed assertions
	int failures = 0;

	// Idle transmitter keeps the line at the stop level
	a_tx_idle_high: assert property (@(posedge clk) disable iff (reset)
		tx_ready |-> uart_tx)
	else
	begin
		failures++;
		$error("uart_tx low while the transmitter is idle");
	end

	// Received character strobe is a single-cycle pulse
	a_rx_valid_pulse: assert property (@(posedge clk) disable iff (reset)
		rx_char_valid |=> !rx_char_valid)
	else
	begin
		failures++;
		$error("rx_char_valid high for two cycles");
	end

	// Launch only while the transmitter can take it, then it goes busy
	a_tx_start_ready: assert property (@(posedge clk) disable iff (reset)
		tx_start |-> tx_ready ##1 !tx_ready)
	else
	begin
		failures++;
		$error("tx_start not taken by an idle transmitter");
	end

	// Pop needs a character, and that character is what the bus reads back
	a_pop_not_empty: assert property (@(posedge clk) disable iff (reset)
		rx_pop |-> !fifo_empty ##1 (io_read_data == 32'($past(fifo_char))))
	else
	begin
		failures++;
		$error("receive FIFO popped while empty or popped character not returned");
	end
endmodule

bind uart_top uart_chk i_chk(
	.clk(clk),
	.reset(reset),
	.uart_tx(uart_tx),
	.tx_ready(tx_ready),
	.tx_start(tx_start),
	.rx_char_valid(rx_char_valid),
	.rx_pop(rx_pop),
	.fifo_empty(fifo_empty),
	.fifo_char(fifo_char),
	.io_read_data(io_read_data));

/* dv/uart_tb.sv */
/*
 * Serial port testbench
 * Bus register access, serial frame driver and line monitor
 */

`timescale 1ns/1ps

`include "uart_config.svh"

module uart_tb;

	import io_bus_pkg::*;
	import uart_types_pkg::*;

	localparam int BAUD = `UART_BAUD_DIVIDE;
	localparam int DEPTH = `UART_FIFO_DEPTH;
	localparam int LINE_TIMEOUT = 40 * BAUD;
	localparam int POLL_LIMIT = 50;

	logic clk;
	logic reset;
	io_addr_t io_address;
	logic io_read_en;
	logic io_write_en;
	io_data_t io_write_data;
	io_data_t io_read_data;
	logic uart_rx;
	logic uart_tx;
	int errors;
	int timeouts;
	integer seed;

	uart_top i_dut(
		.clk(clk),
		.reset(reset),
		.io_address(io_address),
		.io_read_en(io_read_en),
		.io_write_en(io_write_en),
		.io_write_data(io_write_data),
		.io_read_data(io_read_data),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx));

	// 40 ns period
	always #20 clk = ~clk;

	task automatic print_counts();
		$display("Errors %0d, timeouts %0d, assertion failures %0d",
			errors, timeouts, i_dut.i_chk.failures);
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timeout: %s did not happen in time", what);
		print_counts();
		$display("Simulation FAILED");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			errors++;
			$display("error %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	function automatic char_t random_char();
		logic [31:0] word;
		word = $random(seed);
		return word[7:0];
	endfunction

	// Write takes effect at the edge where the strobe is seen
	task automatic bus_write(input io_addr_t addr, input io_data_t data);
		@(posedge clk);
		io_address <= addr;
		io_write_data <= data;
		io_write_en <= 1'b1;
		@(posedge clk);
		io_write_en <= 1'b0;
	endtask

	// Data is registered one clock after the strobe, sampled mid-cycle
	task automatic bus_read(input io_addr_t addr, output io_data_t data);
		@(posedge clk);
		io_address <= addr;
		io_read_en <= 1'b1;
		@(posedge clk);
		io_read_en <= 1'b0;
		@(negedge clk);
		data = io_read_data;
	endtask

	// One bit held for exactly BAUD clocks
	task automatic send_bit(input logic value);
		@(posedge clk);
		uart_rx <= value;
		repeat (BAUD - 1)
			@(posedge clk);
	endtask

	task automatic drive_frame(input char_t c);
		send_bit(1'b0);
		for (int i = 0; i < 8; i++)
			send_bit(c[i]);
		send_bit(1'b1);
	endtask

	task automatic step_negedges(input int n, inout int clocks);
		repeat (n)
		begin
			@(negedge clk);
			clocks++;
		end
	endtask

	// Decodes one frame and counts clocks from start edge to tx_ready
	task automatic capture_tx_frame(output char_t c, output int clocks);
		int wait_count;
		wait_count = 0;
		clocks = 0;
		while (uart_tx !== 1'b0)
		begin
			@(negedge clk);
			wait_count++;
			if (wait_count > LINE_TIMEOUT)
				report_timeout("start bit on uart_tx");
		end
		step_negedges(BAUD / 2, clocks);
		check_value("tx start bit", 32'h0, 32'(uart_tx));
		for (int i = 0; i < 8; i++)
		begin
			step_negedges(BAUD, clocks);
			c[i] = uart_tx;
		end
		step_negedges(BAUD, clocks);
		check_value("tx stop bit", 32'h1, 32'(uart_tx));
		while (i_dut.tx_ready !== 1'b1)
		begin
			step_negedges(1, clocks);
			if (clocks > LINE_TIMEOUT)
				report_timeout("tx_ready after stop bit");
		end
	endtask

	task automatic wait_rx_ready();
		io_data_t status;
		int polls;
		polls = 0;
		bus_read(REG_STATUS, status);
		while (!status[STATUS_RX_READY])
		begin
			polls++;
			if (polls > POLL_LIMIT)
				report_timeout("rx_ready in the status register");
			bus_read(REG_STATUS, status);
		end
	endtask

	task automatic check_reset_state();
		io_data_t data;
		@(negedge clk);
		check_value("reset uart_tx", 32'h1, 32'(uart_tx));
		bus_read(REG_STATUS, data);
		check_value("reset status", 32'h2, data);
		bus_read(REG_RX_DATA, data);
		check_value("reset rx data empty", 32'h0, data);
	endtask

	task automatic test_transmit();
		char_t sent;
		char_t got;
		int clocks;
		int glitches;
		for (int n = 0; n < 3; n++)
		begin
			sent = random_char();
			bus_write(REG_TX_DATA, 32'(sent));
			capture_tx_frame(got, clocks);
			check_value("tx character", 32'(sent), 32'(got));
			check_value("tx frame clocks", 32'(10 * BAUD), 32'(clocks));
		end
		// Second write lands mid-frame and must be dropped
		sent = random_char();
		bus_write(REG_TX_DATA, 32'(sent));
		fork
			capture_tx_frame(got, clocks);
			begin
				repeat (3 * BAUD)
					@(posedge clk);
				bus_write(REG_TX_DATA, 32'(~sent));
			end
		join
		check_value("tx character before busy write", 32'(sent), 32'(got));
		glitches = 0;
		repeat (12 * BAUD)
		begin
			@(negedge clk);
			if (uart_tx !== 1'b1)
				glitches++;
		end
		check_value("tx busy write dropped", 32'h0, 32'(glitches));
	endtask

	task automatic test_receive();
		char_t sent[$];
		io_data_t data;
		for (int n = 0; n < 4; n++)
		begin
			sent.push_back(random_char());
			drive_frame(sent[n]);
		end
		wait_rx_ready();
		foreach (sent[n])
		begin
			bus_read(REG_RX_DATA, data);
			check_value("rx character order", 32'(sent[n]), data);
		end
		bus_read(REG_STATUS, data);
		check_value("rx ready cleared", 32'h0, 32'(data[STATUS_RX_READY]));
	endtask

	task automatic test_overrun();
		char_t sent[$];
		io_data_t data;
		for (int n = 0; n < DEPTH + 2; n++)
		begin
			sent.push_back(random_char());
			drive_frame(sent[n]);
		end
		// Ready, idle transmitter and overrun all set
		bus_read(REG_STATUS, data);
		check_value("overrun status set", 32'h7, data);
		bus_read(REG_STATUS, data);
		check_value("overrun cleared by read", 32'h3, data);
		for (int n = 0; n < DEPTH; n++)
		begin
			bus_read(REG_RX_DATA, data);
			check_value("overrun kept characters", 32'(sent[n]), data);
		end
		bus_read(REG_STATUS, data);
		check_value("overrun fifo drained", 32'h2, data);
	endtask

	task automatic test_full_duplex();
		char_t tx_c;
		char_t rx_c;
		char_t got;
		int clocks;
		io_data_t data;
		tx_c = random_char();
		rx_c = random_char();
		if (rx_c == tx_c)
			rx_c = ~tx_c;
		fork
			begin
				bus_write(REG_TX_DATA, 32'(tx_c));
				capture_tx_frame(got, clocks);
			end
			drive_frame(rx_c);
		join
		check_value("duplex tx character", 32'(tx_c), 32'(got));
		wait_rx_ready();
		bus_read(REG_RX_DATA, data);
		check_value("duplex rx character", 32'(rx_c), data);
	endtask

	initial
	begin
		seed = 32'h0401_e748;
		errors = 0;
		timeouts = 0;
		clk = 1'b0;
		reset = 1'b1;
		io_address = '0;
		io_read_en = 1'b0;
		io_write_en = 1'b0;
		io_write_data = '0;
		uart_rx = 1'b1;
		repeat (5)
			@(posedge clk);
		reset <= 1'b0;

		check_reset_state();
		test_transmit();
		test_receive();
		test_overrun();
		test_full_duplex();

		print_counts();
		if (errors == 0 && i_dut.i_chk.failures == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end
endmodule

/* compile.f */
+incdir+include
logic/uart_types_pkg.sv
logic/io_bus_pkg.sv
logic/synchronizer.sv
logic/uart_receive.sv
logic/uart_transmit.sv
logic/uart_rx_fifo.sv
logic/uart_io_decode.sv
logic/uart_top.sv
dv/uart_chk.sv
dv/uart_tb.sv

/* Makefile */
# Verilator flow for the memory-mapped serial port

VERILATOR ?= verilator
TOP ?= uart_tb
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
RUN_FLAGS ?= +verilator+error+limit+1000
FAIL_MSG ?= Simulation FAILED
PASS_MSG ?= Simulation PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Testbench reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Testbench ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
